// ==== hdl/hub75_pkg.sv ====
// panel geometry, command opcodes and the structs shared across the HUB75 pixel path
// every module imports it and the column, row and plane types follow the geometry
package hub75_pkg;

    localparam int PANEL_WIDTH  = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int HALF_HEIGHT  = PANEL_HEIGHT / 2;  // rows per half and the row address range
    localparam int PLANES       = 4;                  // bit planes per colour channel

    typedef logic [$clog2(PANEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(HALF_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(PLANES)-1:0]      plane_t;

    // 12-bit pixel with red in the top nibble
    typedef struct packed {
        logic [PLANES-1:0] red;
        logic [PLANES-1:0] green;
        logic [PLANES-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    localparam logic [7:0] OP_PIXEL    = 8'h50;  // x, y, pixel hi, pixel lo
    localparam logic [7:0] OP_RGB_EN   = 8'h52;  // one mask byte
    localparam logic [7:0] OP_PLANE_EN = 8'h42;  // one mask byte

    typedef struct packed {
        logic   en_top;
        logic   en_bottom;
        col_t   col;
        row_t   row;
        pixel_t pixel;
    } fb_write_t;

    // rgb_enable bit 2 red, bit 1 green, bit 0 blue
    typedef struct packed {
        logic [2:0]        rgb_enable;
        logic [PLANES-1:0] plane_enable;
    } display_cfg_t;

    typedef struct packed {
        col_t   col;
        row_t   row;
        plane_t plane;
    } fetch_req_t;

    // panel connector
    typedef struct packed {
        rgb_t rgb_top;
        rgb_t rgb_bottom;
        row_t row;
        logic clk_pixel;
        logic latch;
        logic oe_n;
    } hub75_t;

endpackage

// ==== hdl/uart_rx.sv ====
// 8N1 uart receiver for the command stream
// rx is synchronized internally; byte_valid pulses once per frame with a good stop bit
`timescale 1ns/1ps

module uart_rx #(
    parameter int TICKS_PER_BIT = 16
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       byte_valid
);

    localparam int CW = $clog2(TICKS_PER_BIT);

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_BREAK} rx_state_t;

    rx_state_t   state;
    logic        rx_s1, rx_s2;
    logic [CW-1:0] tick;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rx_s1      <= 1'b1;  // line idles high
            rx_s2      <= 1'b1;
            state      <= RX_IDLE;
            tick       <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_s1      <= rx;
            rx_s2      <= rx_s1;
            byte_valid <= 1'b0;
            tick       <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!rx_s2) state <= RX_START;
                end
                RX_START: if (tick == CW'(TICKS_PER_BIT / 2 - 1)) begin
                    tick    <= '0;  // now mid start bit
                    bit_cnt <= '0;
                    state   <= rx_s2 ? RX_IDLE : RX_DATA;  // glitch filter
                end
                RX_DATA: if (tick == CW'(TICKS_PER_BIT - 1)) begin
                    tick    <= '0;
                    shift   <= {rx_s2, shift[7:1]};  // lsb first
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (tick == CW'(TICKS_PER_BIT - 1)) begin
                    if (rx_s2) begin
                        rx_byte    <= shift;
                        byte_valid <= 1'b1;
                        state      <= RX_IDLE;
                    end else begin
                        state <= RX_BREAK;  // framing error drops the frame
                    end
                end
                default: if (rx_s2) state <= RX_IDLE;  // wait out a low line
            endcase
        end
    end

endmodule

// ==== hdl/command_decoder.sv ====
// turns received command bytes into framebuffer writes and the two display masks
// takes one byte per byte_valid pulse and acts the cycle after the last byte
`timescale 1ns/1ps

module command_decoder (
    input  logic                      clk_root,
    input  logic                      rst_n,
    input  logic [7:0]                rx_byte,
    input  logic                      byte_valid,
    output hub75_pkg::fb_write_t      fb_wr,
    output hub75_pkg::display_cfg_t   cfg
);

    import hub75_pkg::*;

    typedef enum logic [2:0] {ST_OP, ST_X, ST_Y, ST_HI, ST_LO, ST_MASK} dec_state_t;

    dec_state_t state;
    logic       mask_is_rgb;  // which mask the next byte goes to
    col_t       x_reg;
    logic [7:0] y_reg;
    logic [3:0] hi_reg;       // red nibble
    logic       y_top;

    assign y_top = (y_reg < 8'(HALF_HEIGHT));

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state <= ST_OP;
            fb_wr <= '0;
            cfg   <= '1;  // everything visible out of reset
        end else begin
            fb_wr.en_top    <= 1'b0;
            fb_wr.en_bottom <= 1'b0;
            if (byte_valid) begin
                case (state)
                    ST_OP: begin
                        mask_is_rgb <= (rx_byte == OP_RGB_EN);
                        if (rx_byte == OP_PIXEL) begin
                            state <= ST_X;
                        end else if (rx_byte == OP_RGB_EN || rx_byte == OP_PLANE_EN) begin
                            state <= ST_MASK;
                        end
                    end
                    ST_X: begin
                        x_reg <= col_t'(rx_byte);
                        state <= ST_Y;
                    end
                    ST_Y: begin
                        y_reg <= rx_byte;
                        state <= ST_HI;
                    end
                    ST_HI: begin
                        hi_reg <= rx_byte[3:0];
                        state  <= ST_LO;
                    end
                    ST_LO: begin
                        fb_wr.en_top    <= y_top;
                        fb_wr.en_bottom <= !y_top;
                        fb_wr.col       <= x_reg;
                        fb_wr.row       <= y_top ? row_t'(y_reg)
                                                 : row_t'(y_reg - 8'(HALF_HEIGHT));
                        fb_wr.pixel     <= pixel_t'({hi_reg, rx_byte});
                        state           <= ST_OP;
                    end
                    default: begin  // mask byte uses the low bits only
                        if (mask_is_rgb) cfg.rgb_enable <= rx_byte[2:0];
                        else cfg.plane_enable <= rx_byte[PLANES-1:0];
                        state <= ST_OP;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/framebuffer_ram.sv ====
// one half of the framebuffer, written by the decoder and read by the scan
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic              clk_root,
    input  logic              we,
    input  hub75_pkg::col_t   wr_col,
    input  hub75_pkg::row_t   wr_row,
    input  hub75_pkg::pixel_t wr_pixel,
    input  hub75_pkg::col_t   rd_col,
    input  hub75_pkg::row_t   rd_row,
    output hub75_pkg::pixel_t rd_pixel
);

    import hub75_pkg::*;

    pixel_t mem [HALF_HEIGHT * PANEL_WIDTH];  // addressed {row, col}

    initial begin
        for (int i = 0; i < HALF_HEIGHT * PANEL_WIDTH; i++) mem[i] = '0;  // blank panel
    end

    always_ff @(posedge clk_root) begin
        if (we) mem[{wr_row, wr_col}] <= wr_pixel;
        rd_pixel <= mem[{rd_row, rd_col}];
    end

endmodule

// ==== hdl/framebuffer_fetch.sv ====
// reads the top and bottom pixel for a scan request and reduces them to one plane
// two-stage pipeline of ram read then bit select and masking; rgb valid 2 cycles after req
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                    clk_root,
    input  logic                    rst_n,
    input  hub75_pkg::fetch_req_t   req,
    input  logic                    req_valid,
    input  hub75_pkg::display_cfg_t cfg,
    input  hub75_pkg::fb_write_t    fb_wr,
    output hub75_pkg::rgb_t         rgb_top,
    output hub75_pkg::rgb_t         rgb_bottom
);

    import hub75_pkg::*;

    pixel_t px_top, px_bottom;
    plane_t plane_d1;
    logic   valid_d1;

    // one bit per channel for this plane, gated by both masks
    function automatic rgb_t plane_bits(pixel_t px, plane_t p, display_cfg_t c);
        rgb_t bits;
        bits.red   = px.red[p] & c.rgb_enable[2];
        bits.green = px.green[p] & c.rgb_enable[1];
        bits.blue  = px.blue[p] & c.rgb_enable[0];
        return bits & {3{c.plane_enable[p]}};
    endfunction

    framebuffer_ram u_ram_top (
        .clk_root (clk_root),
        .we       (fb_wr.en_top),
        .wr_col   (fb_wr.col),
        .wr_row   (fb_wr.row),
        .wr_pixel (fb_wr.pixel),
        .rd_col   (req.col),
        .rd_row   (req.row),
        .rd_pixel (px_top)
    );

    framebuffer_ram u_ram_bottom (
        .clk_root (clk_root),
        .we       (fb_wr.en_bottom),
        .wr_col   (fb_wr.col),
        .wr_row   (fb_wr.row),
        .wr_pixel (fb_wr.pixel),
        .rd_col   (req.col),
        .rd_row   (req.row),
        .rd_pixel (px_bottom)
    );

    always_ff @(posedge clk_root) begin
        plane_d1 <= req.plane;  // rides along with the ram read
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            valid_d1   <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            valid_d1   <= req_valid;
            rgb_top    <= valid_d1 ? plane_bits(px_top, plane_d1, cfg) : '0;
            rgb_bottom <= valid_d1 ? plane_bits(px_bottom, plane_d1, cfg) : '0;
        end
    end

endmodule

// ==== hdl/matrix_scan.sv ====
// row/plane/column sequencer with binary-coded modulation for the HUB75 panel
// requests go out two cycles ahead of the panel; all panel lines are registered
`timescale 1ns/1ps

module matrix_scan #(
    parameter int BASE_TIME = 64  // display cycles of plane 0
) (
    input  logic                  clk_root,
    input  logic                  rst_n,
    input  hub75_pkg::rgb_t       rgb_top,
    input  hub75_pkg::rgb_t       rgb_bottom,
    output hub75_pkg::fetch_req_t req,
    output logic                  req_valid,
    output hub75_pkg::hub75_t     panel
);

    import hub75_pkg::*;

    localparam int DISP_MAX = BASE_TIME << (PLANES - 1);
    localparam int DW       = $clog2(DISP_MAX + 1);

    typedef enum logic [1:0] {PH_SHIFT, PH_LATCH, PH_DISPLAY} phase_t;

    // panel control intent, delayed to line up with fetched rgb
    typedef struct packed {
        logic clk_pixel;
        logic latch;
        logic oe;
        row_t row;
    } scan_ctrl_t;

    phase_t     phase;
    col_t       col;
    logic       half;  // 0 = pixel clock low, 1 = high
    plane_t     plane;
    row_t       row;
    logic [DW-1:0] disp_cnt, disp_last;
    scan_ctrl_t ctrl_now, ctrl_d1, ctrl_d2;

    assign disp_last = DW'((BASE_TIME << plane) - 1);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            phase    <= PH_SHIFT;
            col      <= '0;
            half     <= 1'b0;
            plane    <= '0;
            row      <= '0;
            disp_cnt <= '0;
        end else begin
            case (phase)
                PH_SHIFT: begin
                    half <= !half;
                    if (half) begin
                        col <= col + 1'b1;
                        if (col == col_t'(PANEL_WIDTH - 1)) phase <= PH_LATCH;
                    end
                end
                PH_LATCH: begin
                    disp_cnt <= '0;
                    phase    <= PH_DISPLAY;
                end
                default: begin
                    disp_cnt <= disp_cnt + 1'b1;
                    if (disp_cnt == disp_last) begin
                        phase <= PH_SHIFT;
                        plane <= plane + 1'b1;
                        if (plane == plane_t'(PLANES - 1)) begin
                            plane <= '0;
                            row   <= (row == row_t'(HALF_HEIGHT - 1)) ? '0 : row + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign req.col   = col;
    assign req.row   = row;
    assign req.plane = plane;
    assign req_valid = (phase == PH_SHIFT);  // both halves of a column

    assign ctrl_now.clk_pixel = (phase == PH_SHIFT) && half;
    assign ctrl_now.latch     = (phase == PH_LATCH);
    assign ctrl_now.oe        = (phase == PH_DISPLAY);
    assign ctrl_now.row       = row;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            ctrl_d1 <= '0;
            ctrl_d2 <= '0;
            panel   <= '0;
            panel.oe_n <= 1'b1;  // dark until the first display phase
        end else begin
            ctrl_d1 <= ctrl_now;
            ctrl_d2 <= ctrl_d1;  // matches fetch latency
            panel.rgb_top    <= rgb_top;
            panel.rgb_bottom <= rgb_bottom;
            panel.clk_pixel  <= ctrl_d2.clk_pixel;
            panel.latch      <= ctrl_d2.latch;
            panel.oe_n       <= !ctrl_d2.oe;
            if (ctrl_d2.latch) panel.row <= ctrl_d2.row;  // row just shifted
        end
    end

endmodule

// ==== hdl/hub75_top.sv ====
// top of the HUB75 pixel path with uart commands in and the panel connector out
// baud and display time base are set here and passed down
`timescale 1ns/1ps

module hub75_top #(
    parameter int BAUD_TICKS = 217,  // clk_root cycles per uart bit
    parameter int BASE_TIME  = 64
) (
    input  logic              clk_root,
    input  logic              rst_n,
    input  logic              rx,
    output hub75_pkg::hub75_t panel
);

    import hub75_pkg::*;

    logic [7:0]   rx_byte;
    logic         byte_valid;
    fb_write_t    fb_wr;
    display_cfg_t cfg;
    fetch_req_t   req;
    logic         req_valid;
    rgb_t         rgb_top, rgb_bottom;

    uart_rx #(
        .TICKS_PER_BIT (BAUD_TICKS)
    ) u_uart_rx (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    command_decoder u_command_decoder (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .fb_wr      (fb_wr),
        .cfg        (cfg)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .cfg        (cfg),
        .fb_wr      (fb_wr),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom)
    );

    matrix_scan #(
        .BASE_TIME (BASE_TIME)
    ) u_matrix_scan (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .req        (req),
        .req_valid  (req_valid),
        .panel      (panel)
    );

endmodule

// ==== sim/tb_hub75.sv ====
// self-checking testbench for the HUB75 pixel path
// sends uart commands and checks every panel line against a reference model
`timescale 1ns/1ps

module tb_hub75;

    import hub75_pkg::*;

    localparam int BAUD_TICKS   = 8;
    localparam int BASE_TIME    = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    // shift, latch and display time for every plane of every row
    localparam int FRAME_CYCLES = HALF_HEIGHT * (PLANES * (2 * PANEL_WIDTH + 1)
                                  + BASE_TIME * ((1 << PLANES) - 1));
    localparam int NUM_BYTES    = 5 * PANEL_WIDTH * PANEL_HEIGHT + 10;  // pixels plus masks
    localparam int CHECK_FRAMES = 5;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_BYTES * 10 * BAUD_TICKS
                                     + (CHECK_FRAMES + 3) * FRAME_CYCLES;

    logic   clk_root = 1'b0;
    logic   rst_n;
    logic   rx;
    hub75_t panel;

    logic [11:0]       model_fb [2][HALF_HEIGHT][PANEL_WIDTH];  // [half][row][col]
    logic [2:0]        model_rgb_en;
    logic [PLANES-1:0] model_plane_en;
    logic [31:0]       seed;

    logic data_check;  // rgb compare only while the model is settled
    int   latch_count;
    int   mon_col;
    int   mon_plane;
    int   mon_row;
    int   oe_cnt;
    logic in_display;

    hub75_top #(
        .BAUD_TICKS (BAUD_TICKS),
        .BASE_TIME  (BASE_TIME)
    ) u_dut (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .rx       (rx),
        .panel    (panel)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_root = ~clk_root;
    end

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one plane bit per channel, gated by the channel and plane masks
    function automatic logic [2:0] expected_rgb(input int half, input int row, input int col,
                                                input int plane);
        logic [11:0] px;
        logic [2:0]  bits;
        px      = model_fb[half][row][col];
        bits[2] = px[8 + plane];
        bits[1] = px[4 + plane];
        bits[0] = px[plane];
        return bits & model_rgb_en & {3{model_plane_en[plane]}};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
            stop_with_failure("panel output differs from the reference model");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_root);
        #2;
    endtask

    task automatic uart_send(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];  // lsb first after the start bit
            repeat (BAUD_TICKS) next_cycle();
        end
    endtask

    task automatic write_pixel(input int x, input int y, input logic [11:0] val);
        uart_send(OP_PIXEL, 1'b1);
        uart_send(8'(x), 1'b1);
        uart_send(8'(y), 1'b1);
        uart_send({4'h0, val[11:8]}, 1'b1);
        uart_send(val[7:0], 1'b1);
        if (y < HALF_HEIGHT) model_fb[0][y][x] = val;
        else model_fb[1][y - HALF_HEIGHT][x] = val;
    endtask

    task automatic set_mask(input logic [7:0] op, input logic [7:0] mask);
        uart_send(op, 1'b1);
        uart_send(mask, 1'b1);
        if (op == OP_RGB_EN) model_rgb_en = mask[2:0];
        else model_plane_en = mask[PLANES-1:0];
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_count + n;
        wait (latch_count >= target);
    endtask

    task automatic check_frames(input int frames);
        repeat (2) next_cycle();
        wait_latches(1);  // the shift after this latch reads settled data
        data_check = 1'b1;
        wait_latches(frames * HALF_HEIGHT * PLANES);
        data_check = 1'b0;
        next_cycle();
    endtask

    // follows column, plane and row from the panel lines alone
    always @(negedge clk_root) begin
        if (!rst_n) begin
            check_value("panel.oe_n", 32'(panel.oe_n), 32'd1);
            check_value("panel.clk_pixel", 32'(panel.clk_pixel), 32'd0);
            check_value("panel.latch", 32'(panel.latch), 32'd0);
            check_value("panel.rgb_top", 32'(panel.rgb_top), 32'd0);
            check_value("panel.rgb_bottom", 32'(panel.rgb_bottom), 32'd0);
            check_value("panel.row", 32'(panel.row), 32'd0);
            mon_col     = 0;
            mon_plane   = 0;
            mon_row     = 0;
            oe_cnt      = 0;
            in_display  = 1'b0;
            latch_count = 0;
        end else begin
            if (panel.latch) begin
                if (in_display) stop_with_failure("latch came before the display time ended");
                check_value("panel.clk_pixel count", 32'(mon_col), 32'(PANEL_WIDTH));
                check_value("panel.row", 32'(panel.row), 32'(mon_row));
                check_value("panel.oe_n", 32'(panel.oe_n), 32'd1);
                mon_col     = 0;
                oe_cnt      = 0;
                in_display  = 1'b1;
                latch_count = latch_count + 1;
            end else if (!panel.oe_n) begin
                if (!in_display) stop_with_failure("oe_n went low outside a display period");
                oe_cnt = oe_cnt + 1;
            end else if (in_display) begin
                // display just ended so the next plane or row starts shifting
                check_value("panel.oe_n low cycles", 32'(oe_cnt), 32'(BASE_TIME << mon_plane));
                in_display = 1'b0;
                mon_plane  = mon_plane + 1;
                if (mon_plane == PLANES) begin
                    mon_plane = 0;
                    mon_row   = (mon_row + 1) % HALF_HEIGHT;
                end
            end
            if (panel.latch || !panel.oe_n) begin
                // no column is being shifted in these cycles
                check_value("panel.rgb_top", 32'(panel.rgb_top), 32'd0);
                check_value("panel.rgb_bottom", 32'(panel.rgb_bottom), 32'd0);
            end else if (data_check) begin
                // column data holds over both pixel clock phases
                check_value("panel.rgb_top", 32'(panel.rgb_top),
                            32'(expected_rgb(0, mon_row, mon_col % PANEL_WIDTH, mon_plane)));
                check_value("panel.rgb_bottom", 32'(panel.rgb_bottom),
                            32'(expected_rgb(1, mon_row, mon_col % PANEL_WIDTH, mon_plane)));
            end
            if (panel.clk_pixel) begin
                check_value("panel.oe_n", 32'(panel.oe_n), 32'd1);
                mon_col = mon_col + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        rx             = 1'b1;
        rst_n          = 1'b0;
        data_check     = 1'b0;
        model_rgb_en   = 3'b111;
        model_plane_en = '1;
        seed           = 32'h76cd;
        for (int h = 0; h < 2; h++) begin
            for (int r = 0; r < HALF_HEIGHT; r++) begin
                for (int c = 0; c < PANEL_WIDTH; c++) model_fb[h][r][c] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk_root);
        #2;
        rst_n = 1'b1;

        for (int y = 0; y < PANEL_HEIGHT; y++) begin
            for (int x = 0; x < PANEL_WIDTH; x++) begin
                seed = lcg(seed);
                write_pixel(x, y, seed[27:16]);
            end
        end
        check_frames(2);

        set_mask(OP_PLANE_EN, 8'h05);  // planes 1 and 3 dark
        check_frames(1);

        uart_send(8'h33, 1'b1);         // not an opcode
        set_mask(OP_PLANE_EN, 8'hff);   // high bits ignored
        set_mask(OP_RGB_EN, 8'h05);     // green off
        check_frames(1);

        // if the broken frame were taken, the rgb command would land as a plane mask
        uart_send(OP_PLANE_EN, 1'b0);
        rx = 1'b1;
        repeat (2 * BAUD_TICKS) next_cycle();
        set_mask(OP_RGB_EN, 8'h06);     // blue off
        check_frames(1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/hub75_pkg.sv
hdl/uart_rx.sv
hdl/command_decoder.sv
hdl/framebuffer_ram.sv
hdl/framebuffer_fetch.sv
hdl/matrix_scan.sv
hdl/hub75_top.sv
sim/tb_hub75.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the HUB75 pixel path with its testbench under Verilator and run it
# the exit status of the simulation is the test result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_hub75 -f build.f -o tb_hub75_sim

./obj_dir/tb_hub75_sim
